// ==== bench/ramio_tb_checks.svh ====
// ramio testbench model and compare tasks
// reference word ram with byte lanes, read extension and typed checks
`ifndef RAMIO_TB_CHECKS_SVH
`define RAMIO_TB_CHECKS_SVH

int errors = 0;
ramio_pkg::word_t ref_mem [ramio_pkg::ram_words];

// store the written lanes
function automatic void model_write(input ramio_pkg::addr_t a, input ramio_pkg::write_type_t wt,
                                    input ramio_pkg::word_t d);
  case (wt)
    2'd1: ref_mem[a[9:2]][a[1:0]*8 +: 8] = d[7:0];
    // odd address half word is dropped
    2'd2: if (!a[0]) begin
      if (a[1]) ref_mem[a[9:2]][31:16] = d[15:0];
      else      ref_mem[a[9:2]][15:0]  = d[15:0];
    end
    2'd3: ref_mem[a[9:2]] = d;
    default: ;
  endcase
endfunction

// expected data_out of a ram read
function automatic ramio_pkg::word_t model_read(input ramio_pkg::addr_t a,
                                                input ramio_pkg::read_type_t rt);
  ramio_pkg::word_t w;
  logic [7:0]       b;
  logic [15:0]      h;
  w = ref_mem[a[9:2]];
  b = w[a[1:0]*8 +: 8];
  h = a[1] ? w[31:16] : w[15:0];
  case (rt[1:0])
    2'd1: return rt[2] ? {{24{b[7]}}, b} : {24'b0, b};
    // odd address half word gives zero
    2'd2: return a[0] ? '0 : (rt[2] ? {{16{h[15]}}, h} : {16'b0, h});
    2'd3: return w;
    default: return '0;
  endcase
endfunction

task automatic report_fault(input string what);
  errors++;
  $display("%0t: %s", $time, what);
endtask

task automatic check_word(input ramio_pkg::word_t got, input ramio_pkg::word_t exp,
                          input string what);
  if (got !== exp) begin
    errors++;
    $display("CHECK FAILED at %0t: %s, got %h expected %h", $time, what, got, exp);
  end
endtask

task automatic check_led(input ramio_pkg::led_t got, input ramio_pkg::led_t exp, input string what);
  if (got !== exp) begin
    errors++;
    $display("CHECK FAILED at %0t: %s, got %b expected %b", $time, what, got, exp);
  end
endtask

task automatic check_byte(input ramio_pkg::byte_t got, input ramio_pkg::byte_t exp,
                          input string what);
  if (got !== exp) begin
    errors++;
    $display("CHECK FAILED at %0t: %s, got %h expected %h", $time, what, got, exp);
  end
endtask

// handshake levels
task automatic check_level(input logic got, input logic exp, input string what);
  if (got !== exp) begin
    errors++;
    $display("CHECK FAILED at %0t: %s, got %b expected %b", $time, what, got, exp);
  end
endtask

`endif

// ==== bench/ramio_tb.sv ====
// ramio testbench
// random ram and led traffic against a reference model
// uart frames in both directions
`timescale 1ns/1ps

module ramio_tb;

  localparam int n_random = 400;
  localparam int n_tx = 4;
  localparam int n_rx = 4;
  // bus accesses including the mailbox polls
  localparam int n_accesses = ramio_pkg::ram_words + n_random + 4 +
                              (n_tx + n_rx + 1) * (2 * ramio_pkg::clks_per_bit + 2);
  localparam int cycle_limit = n_accesses * 4 +
                               (n_tx + n_rx + 2) * 12 * ramio_pkg::clks_per_bit + 500;

  logic                   clk;
  logic                   rst_n;
  logic                   enable;
  ramio_pkg::read_type_t  read_type;
  ramio_pkg::write_type_t write_type;
  ramio_pkg::addr_t       address;
  ramio_pkg::word_t       data_in;
  ramio_pkg::word_t       data_out;
  logic                   data_out_ready;
  logic                   busy;
  ramio_pkg::led_t        led;
  logic                   uart_tx;
  logic                   uart_rx;
  ramio_pkg::byte_t       tx_seen [$];
  int                     cycles = 0;

  `include "ramio_tb_checks.svh"

  ramio dut0 (
    .clk, .rst_n, .enable, .read_type, .write_type, .address, .data_in,
    .data_out, .data_out_ready, .busy, .led, .uart_tx, .uart_rx
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  // hard stop for a stuck handshake
  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= cycle_limit) begin
      $display("timeout: run stopped after %0d cycles with %0d errors", cycles, errors);
      $display("Test failed");
      $finish;
    end
  end

  // ----------------------------------------------------------------------------
  // bus tasks
  // inputs change 2 ns after the edge and outputs are sampled at negedge
  function automatic void release_bus();
    enable     = 1'b0;
    read_type  = '0;
    write_type = '0;
  endfunction

  task automatic io_access(input ramio_pkg::addr_t a, input ramio_pkg::read_type_t rt,
                           input ramio_pkg::write_type_t wt, input ramio_pkg::word_t d,
                           output ramio_pkg::word_t got);
    @(posedge clk);
    #2;
    enable = 1'b1;
    read_type = rt;
    write_type = wt;
    address = a;
    data_in = d;
    @(negedge clk);
    check_level(data_out_ready, 1'b1, "i/o access ready in first cycle");
    check_level(busy, 1'b0, "i/o access busy");
    got = data_out;
    @(posedge clk);
    #2;
    release_bus();
  endtask

  task automatic ram_write(input ramio_pkg::addr_t a, input ramio_pkg::write_type_t wt,
                           input ramio_pkg::word_t d);
    @(posedge clk);
    #2;
    enable = 1'b1;
    write_type = wt;
    address = a;
    data_in = d;
    @(negedge clk);
    check_level(data_out_ready, 1'b1, "ram write ready in first cycle");
    check_level(busy, 1'b0, "ram write busy");
    @(posedge clk);
    #2;
    release_bus();
    model_write(a, wt, d);
  endtask

  task automatic ram_read(input ramio_pkg::addr_t a, input ramio_pkg::read_type_t rt);
    int waited;
    @(posedge clk);
    #2;
    enable = 1'b1;
    read_type = rt;
    address = a;
    @(negedge clk);
    check_level(busy, 1'b1, "busy in first cycle of ram read");
    check_level(data_out_ready, 1'b0, "data_out_ready in first cycle of ram read");
    waited = 0;
    while (data_out_ready !== 1'b1 && waited < 4) begin
      @(negedge clk);
      waited++;
    end
    if (data_out_ready !== 1'b1) begin
      report_fault($sformatf("ram read of %h never raised data_out_ready", a));
    end else begin
      if (waited != 1) report_fault($sformatf("ram read ready in cycle %0d", waited + 1));
      check_level(busy, 1'b0, "busy while ram read ready");
      check_word(data_out, model_read(a, rt), $sformatf("ram read %h type %0d", a, rt));
    end
    @(posedge clk);
    #2;
    release_bus();
  endtask

  task automatic led_write(input ramio_pkg::word_t d);
    ramio_pkg::word_t got;
    io_access(ramio_pkg::addr_led, 3'd0, 2'd3, d, got);
    @(negedge clk);
    check_led(led, d[3:0], "led after write");
  endtask

  // ----------------------------------------------------------------------------
  // serial side
  task automatic send_frame(input ramio_pkg::byte_t b);
    logic [9:0] frame;
    frame = {1'b1, b, 1'b0};
    for (int i = 0; i < 10; i++) begin
      @(posedge clk);
      #2;
      uart_rx = frame[i];
      repeat (ramio_pkg::clks_per_bit - 1) @(posedge clk);
    end
  endtask

  // decode uart_tx at mid-bit
  initial begin : tx_monitor
    ramio_pkg::byte_t b;
    wait (rst_n === 1'b1);
    forever begin
      @(negedge uart_tx);
      repeat (ramio_pkg::clks_per_bit / 2) @(negedge clk);
      check_level(uart_tx, 1'b0, "uart_tx start bit at mid-bit");
      for (int i = 0; i < 8; i++) begin
        repeat (ramio_pkg::clks_per_bit) @(negedge clk);
        b[i] = uart_tx;
      end
      repeat (ramio_pkg::clks_per_bit) @(negedge clk);
      check_level(uart_tx, 1'b1, "uart_tx stop bit");
      tx_seen.push_back(b);
    end
  end

  task automatic expect_tx_frame(input ramio_pkg::byte_t b);
    int waited;
    ramio_pkg::word_t got;
    waited = 0;
    while (tx_seen.size() == 0 && waited < 12 * ramio_pkg::clks_per_bit) begin
      @(posedge clk);
      waited++;
    end
    if (tx_seen.size() == 0) begin
      report_fault("no frame came out on uart_tx");
    end else begin
      check_byte(tx_seen.pop_front(), b, "byte decoded from uart_tx");
    end
    // mailbox empties once the transmitter is released
    got = '0;
    for (int n = 0; n < ramio_pkg::clks_per_bit && got !== ramio_pkg::mailbox_empty; n++) begin
      io_access(ramio_pkg::addr_uart_out, 3'd3, 2'd0, '0, got);
    end
    check_word(got, ramio_pkg::mailbox_empty, "out mailbox after frame");
  endtask

  task automatic expect_rx_byte(input ramio_pkg::byte_t b);
    ramio_pkg::word_t got;
    got = ramio_pkg::mailbox_empty;
    for (int n = 0; n < 2 * ramio_pkg::clks_per_bit && got === ramio_pkg::mailbox_empty; n++) begin
      io_access(ramio_pkg::addr_uart_in, 3'd3, 2'd0, '0, got);
    end
    if (got === ramio_pkg::mailbox_empty) report_fault("no byte arrived in the in mailbox");
    else check_word(got, {24'b0, b}, "in mailbox after frame");
    io_access(ramio_pkg::addr_uart_in, 3'd3, 2'd0, '0, got);
    check_word(got, ramio_pkg::mailbox_empty, "in mailbox after read");
  endtask

  // ----------------------------------------------------------------------------
  initial begin : stimulus
    int unsigned            seed;
    int                     kind;
    ramio_pkg::addr_t       a;
    ramio_pkg::word_t       d;
    ramio_pkg::word_t       got;
    ramio_pkg::read_type_t  rt;
    ramio_pkg::write_type_t wt;
    ramio_pkg::byte_t       b;
    seed = $urandom(32'hfb61);
    rst_n = 1'b0;
    address = '0;
    data_in = '0;
    uart_rx = 1'b1;
    release_bus();
    repeat (4) @(posedge clk);
    #2;
    rst_n = 1'b1;

    // reset state
    @(negedge clk);
    check_led(led, '1, "led after reset");
    check_level(uart_tx, 1'b1, "uart_tx after reset");
    io_access(ramio_pkg::addr_uart_out, 3'd3, 2'd0, '0, got);
    check_word(got, ramio_pkg::mailbox_empty, "out mailbox after reset");
    io_access(ramio_pkg::addr_uart_in, 3'd3, 2'd0, '0, got);
    check_word(got, ramio_pkg::mailbox_empty, "in mailbox after reset");

    // known contents everywhere before random reads
    for (int i = 0; i < ramio_pkg::ram_words; i++) ram_write(i * 4, 2'd3, $urandom);

    for (int n = 0; n < n_random; n++) begin
      kind = $urandom_range(0, 9);
      a = $urandom_range(0, 1023);
      d = $urandom;
      if (kind < 4) begin
        wt = ramio_pkg::write_type_t'($urandom_range(1, 3));
        if (wt == 2'd3) a[1:0] = 2'b00;
        ram_write(a, wt, d);
      end else if (kind < 9) begin
        rt = {1'($urandom_range(0, 1)), 2'($urandom_range(1, 3))};
        if (rt[1:0] == 2'd3) a[1:0] = 2'b00;
        ram_read(a, rt);
      end else begin
        led_write(d);
      end
    end

    // transmit path
    for (int k = 0; k < n_tx; k++) begin
      d = $urandom;
      io_access(ramio_pkg::addr_uart_out, 3'd0, 2'd3, d, got);
      io_access(ramio_pkg::addr_uart_out, 3'd3, 2'd0, '0, got);
      check_word(got, {24'b0, d[7:0]}, "out mailbox while sending");
      expect_tx_frame(d[7:0]);
    end

    // receive path
    for (int k = 0; k < n_rx; k++) begin
      b = $urandom;
      send_frame(b);
      expect_rx_byte(b);
    end
    // overrun keeps the later byte
    send_frame($urandom);
    b = $urandom;
    send_frame(b);
    expect_rx_byte(b);

    $display("run finished with %0d errors", errors);
    if (errors == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

// ==== common/ramio_pkg.sv ====
// ramio shared definitions
// bus widths, i/o map, ram depth, uart bit period and fsm state encodings

package ramio_pkg;

  // client bus and ram data
  typedef logic [31:0] word_t;
  typedef logic [31:0] addr_t;
  typedef logic [7:0]  byte_t;
  typedef logic [3:0]  byte_en_t;

  // active low, 0 lights the led
  typedef logic [3:0]  led_t;

  // bit 2 = sign extend, bits 1:0 = size (1 byte, 2 half, 3 word), 0 = no read
  typedef logic [2:0]  read_type_t;
  // 0 = no write, 1 byte, 2 half, 3 word
  typedef logic [1:0]  write_type_t;

  // ------------------------------------------------------------------------
  // i/o map, everything from io_base upwards is i/o
  localparam addr_t addr_led      = 32'hffff_fffc;
  localparam addr_t addr_uart_out = 32'hffff_fff8;
  localparam addr_t addr_uart_in  = 32'hffff_fff4;
  localparam addr_t io_base       = 32'hffff_fff4;

  // word ram, index from address bits 9:2
  localparam int ram_words = 256;
  typedef logic [$clog2(ram_words)-1:0] ram_index_t;

  // uart bit period in clock cycles
  localparam int clks_per_bit = 16;

  // value of an idle or empty mailbox
  localparam word_t mailbox_empty = '1;

  // ------------------------------------------------------------------------
  typedef enum logic [2:0] {tx_idle, tx_start, tx_data, tx_stop, tx_done} tx_state_t;
  typedef enum logic [2:0] {rx_idle, rx_start, rx_data, rx_stop, rx_full} rx_state_t;

endpackage

// ==== hdl/ram_word.sv ====
// ram_word
// byte enabled word ram, one cycle read latency with busy/ready levels
`timescale 1ns/1ps

module ram_word (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  en,
  input  ramio_pkg::byte_en_t   we,
  input  ramio_pkg::ram_index_t index,
  input  ramio_pkg::word_t      wdata,
  output ramio_pkg::word_t      rdata,
  output logic                  ready,
  output logic                  busy
);

  ramio_pkg::word_t      mem [ramio_pkg::ram_words];
  ramio_pkg::ram_index_t last_index;
  logic                  valid;
  logic                  hit;

  // write enabled lanes, capture the word every enabled cycle
  always_ff @(posedge clk) begin
    if (en) begin
      for (int i = 0; i < $bits(ramio_pkg::byte_en_t); i++) begin
        if (we[i]) mem[index][8*i +: 8] <= wdata[8*i +: 8];
      end
      rdata <= mem[index];
    end
    last_index <= index;
  end

  // read captured last cycle, cleared when en drops or a write comes
  always_ff @(posedge clk) begin
    if (!rst_n) valid <= 1'b0;
    else        valid <= en && (we == '0);
  end

  // a changed index needs a fresh capture
  assign hit   = valid && (index == last_index);
  assign ready = en && ((we != '0) || hit);
  assign busy  = en && (we == '0) && !hit;

  a_we_needs_en: assert property (@(posedge clk) disable iff (!rst_n) (we != '0) |-> en);

endmodule

// ==== hdl/ramio.sv ====
// ramio bridge
// decodes client accesses into word ram, led register and uart mailboxes
// byte lane steering on ram writes, sign or zero extension on ram reads
`timescale 1ns/1ps

module ramio (
  input  logic                     clk,
  input  logic                     rst_n,
  input  logic                     enable,
  input  ramio_pkg::read_type_t    read_type,
  input  ramio_pkg::write_type_t   write_type,
  input  ramio_pkg::addr_t         address,
  input  ramio_pkg::word_t         data_in,
  output ramio_pkg::word_t         data_out,
  output logic                     data_out_ready,
  output logic                     busy,
  output ramio_pkg::led_t          led,
  output logic                     uart_tx,
  input  logic                     uart_rx
);

  // address decode
  logic is_io;
  logic is_led;
  logic is_uart_out;
  logic is_uart_in;
  logic is_read;
  logic is_write;

  // ram port
  logic                  ram_en;
  ramio_pkg::byte_en_t   ram_we;
  ramio_pkg::ram_index_t ram_index;
  ramio_pkg::word_t      ram_wdata;
  ramio_pkg::word_t      ram_rdata;
  ramio_pkg::word_t      lane;
  logic                  ram_ready;
  logic                  ram_busy;

  // mailboxes and handshake levels
  ramio_pkg::word_t tx_mailbox;
  ramio_pkg::word_t rx_mailbox;
  logic             tx_go;
  logic             tx_busy;
  logic             rx_go;
  logic             rx_data_ready;
  ramio_pkg::byte_t rx_data;

  assign is_io       = address >= ramio_pkg::io_base;
  assign is_led      = address == ramio_pkg::addr_led;
  assign is_uart_out = address == ramio_pkg::addr_uart_out;
  assign is_uart_in  = address == ramio_pkg::addr_uart_in;
  assign is_read     = enable && (read_type != '0);
  assign is_write    = enable && (write_type != '0);

  // i/o and all writes complete at once
  // ram reads wait for the ram port
  assign data_out_ready = enable && (is_io || is_write || ram_ready);
  assign busy           = !is_io && ram_busy;

  // ------------------------------------------------------------------------
  // write lane steering
  always_comb begin
    ram_we    = '0;
    ram_wdata = data_in << (8 * address[1:0]);
    unique case (write_type)
      2'd1: ram_we = ramio_pkg::byte_en_t'(4'b0001 << address[1:0]);
      // misaligned half word leaves all lanes off
      2'd2: if (!address[0]) ram_we = address[1] ? 4'b1100 : 4'b0011;
      2'd3: ram_we = 4'b1111;
      default: ram_we = '0;
    endcase
    if (!enable || is_io) ram_we = '0;
  end

  assign ram_index = address[2 +: $bits(ramio_pkg::ram_index_t)];
  assign ram_en    = !is_io && (is_read || (ram_we != '0));

  // ------------------------------------------------------------------------
  // read mux and extension
  assign lane = ram_rdata >> (8 * address[1:0]);

  always_comb begin
    data_out = '0;
    if (is_read) begin
      if (is_uart_out) begin
        data_out = tx_mailbox;
      end else if (is_uart_in) begin
        data_out = rx_mailbox;
      end else if (!is_io) begin
        unique case (read_type[1:0])
          2'd1: data_out = {{24{read_type[2] & lane[7]}}, lane[7:0]};
          // misaligned half word reads zero
          2'd2: if (!address[0]) data_out = {{16{read_type[2] & lane[15]}}, lane[15:0]};
          2'd3: data_out = ram_rdata;
          default: data_out = '0;
        endcase
      end
    end
  end

  // ------------------------------------------------------------------------
  // led register, mailboxes and go levels
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      led        <= '1;
      tx_mailbox <= ramio_pkg::mailbox_empty;
      tx_go      <= 1'b0;
      rx_mailbox <= ramio_pkg::mailbox_empty;
      rx_go      <= 1'b1;
    end else begin
      // reading the in mailbox empties it
      if (is_read && is_uart_in) rx_mailbox <= ramio_pkg::mailbox_empty;
      // new byte overwrites an unread one and acks with go low
      if (rx_go && rx_data_ready) begin
        rx_mailbox <= {24'b0, rx_data};
        rx_go      <= 1'b0;
      end
      // one cycle ack then rearm
      if (!rx_go) rx_go <= 1'b1;
      // release the transmitter once the frame is sent
      if (tx_go && !tx_busy) begin
        tx_go      <= 1'b0;
        tx_mailbox <= ramio_pkg::mailbox_empty;
      end
      if (is_write && is_uart_out) begin
        tx_mailbox <= {24'b0, data_in[7:0]};
        tx_go      <= 1'b1;
      end
      if (is_write && is_led) led <= data_in[3:0];
    end
  end

  ram_word ram0 (
    .clk,
    .rst_n,
    .en    (ram_en),
    .we    (ram_we),
    .index (ram_index),
    .wdata (ram_wdata),
    .rdata (ram_rdata),
    .ready (ram_ready),
    .busy  (ram_busy)
  );

  uart_tx tx0 (
    .clk,
    .rst_n,
    .go   (tx_go),
    .data (tx_mailbox[7:0]),
    .busy (tx_busy),
    .tx   (uart_tx)
  );

  uart_rx rx0 (
    .clk,
    .rst_n,
    .go         (rx_go),
    .rx         (uart_rx),
    .data       (rx_data),
    .data_ready (rx_data_ready)
  );

  // client protocol
  a_no_rw_mix: assert property (@(posedge clk) disable iff (!rst_n)
    enable |-> !((read_type != '0) && (write_type != '0)));
  a_word_aligned: assert property (@(posedge clk) disable iff (!rst_n)
    enable && ((read_type[1:0] == 2'd3) || (write_type == 2'd3)) |-> address[1:0] == 2'b00);

endmodule

// ==== list.f ====
+incdir+bench
common/ramio_pkg.sv
uart/baud_timer.sv
uart/uart_tx.sv
uart/uart_rx.sv
hdl/ram_word.sv
hdl/ramio.sv
bench/ramio_tb.sv

// ==== uart/baud_timer.sv ====
// baud_timer
// bit period counter giving one tick per clks_per_bit cycles while run is held
// start_at_half puts the first tick at mid-bit
`timescale 1ns/1ps

module baud_timer #(
  parameter bit start_at_half = 1'b0
) (
  input  logic clk,
  input  logic rst_n,
  input  logic run,
  output logic tick
);

  typedef logic [$clog2(ramio_pkg::clks_per_bit)-1:0] count_t;

  count_t count;

  // tick in the last cycle of each bit period
  assign tick = run && (count == '0);

  // count down to zero and reload a full period
  always_ff @(posedge clk) begin
    if (!rst_n || !run) begin
      count <= start_at_half ? count_t'(ramio_pkg::clks_per_bit / 2 - 1)
                             : count_t'(ramio_pkg::clks_per_bit - 1);
    end else if (count == '0) begin
      count <= count_t'(ramio_pkg::clks_per_bit - 1);
    end else begin
      count <= count - 1'b1;
    end
  end

endmodule

// ==== uart/uart_rx.sv ====
// uart_rx
// 8n1 receiver, mid-bit sampling, go/data_ready handshake
// frames with a bad stop bit are dropped
`timescale 1ns/1ps

module uart_rx (
  input  logic             clk,
  input  logic             rst_n,
  input  logic             go,
  input  logic             rx,
  output ramio_pkg::byte_t data,
  output logic             data_ready
);

  ramio_pkg::rx_state_t state;
  ramio_pkg::byte_t     shreg;
  logic [2:0]           bit_idx;
  logic                 rx_meta;
  logic                 rx_sync;
  logic                 rx_last;
  logic                 tick;

  // two flop synchronizer plus edge history
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      rx_meta <= 1'b1;
      rx_sync <= 1'b1;
      rx_last <= 1'b1;
    end else begin
      rx_meta <= rx;
      rx_sync <= rx_meta;
      rx_last <= rx_sync;
    end
  end

  // first tick lands mid start bit
  baud_timer #(.start_at_half(1'b1)) timer0 (
    .clk,
    .rst_n,
    .run  (state inside {ramio_pkg::rx_start, ramio_pkg::rx_data, ramio_pkg::rx_stop}),
    .tick
  );

  assign data       = shreg;
  assign data_ready = state == ramio_pkg::rx_full;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state   <= ramio_pkg::rx_idle;
      bit_idx <= '0;
    end else begin
      unique case (state)
        // falling edge on the line
        ramio_pkg::rx_idle: if (go && rx_last && !rx_sync) state <= ramio_pkg::rx_start;
        // still low at mid-bit, else a glitch
        ramio_pkg::rx_start: if (tick) begin
          bit_idx <= '0;
          state   <= rx_sync ? ramio_pkg::rx_idle : ramio_pkg::rx_data;
        end
        ramio_pkg::rx_data: if (tick) begin
          shreg <= {rx_sync, shreg[7:1]};
          if (bit_idx == 3'd7) state <= ramio_pkg::rx_stop;
          else                 bit_idx <= bit_idx + 3'd1;
        end
        // framing error drops the byte
        ramio_pkg::rx_stop: if (tick) begin
          state <= rx_sync ? ramio_pkg::rx_full : ramio_pkg::rx_idle;
        end
        // go low is the ack
        ramio_pkg::rx_full: if (!go) state <= ramio_pkg::rx_idle;
        default: state <= ramio_pkg::rx_idle;
      endcase
    end
  end

endmodule

// ==== uart/uart_tx.sv ====
// uart_tx
// 8n1 transmitter, lsb first, go/busy handshake
`timescale 1ns/1ps

module uart_tx (
  input  logic             clk,
  input  logic             rst_n,
  input  logic             go,
  input  ramio_pkg::byte_t data,
  output logic             busy,
  output logic             tx
);

  ramio_pkg::tx_state_t state;
  ramio_pkg::byte_t     shreg;
  logic [2:0]           bit_idx;
  logic                 tick;

  baud_timer #(.start_at_half(1'b0)) timer0 (
    .clk,
    .rst_n,
    .run  (state inside {ramio_pkg::tx_start, ramio_pkg::tx_data, ramio_pkg::tx_stop}),
    .tick
  );

  // busy as soon as go is seen, low again in tx_done
  assign busy = (state == ramio_pkg::tx_idle) ? go : (state != ramio_pkg::tx_done);

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state   <= ramio_pkg::tx_idle;
      tx      <= 1'b1;
      bit_idx <= '0;
    end else begin
      unique case (state)
        ramio_pkg::tx_idle: if (go) begin
          shreg <= data;
          tx    <= 1'b0;
          state <= ramio_pkg::tx_start;
        end
        // start bit done, first data bit out
        ramio_pkg::tx_start: if (tick) begin
          tx      <= shreg[0];
          shreg   <= {1'b1, shreg[7:1]};
          bit_idx <= '0;
          state   <= ramio_pkg::tx_data;
        end
        ramio_pkg::tx_data: if (tick) begin
          if (bit_idx == 3'd7) begin
            tx    <= 1'b1;
            state <= ramio_pkg::tx_stop;
          end else begin
            tx      <= shreg[0];
            shreg   <= {1'b1, shreg[7:1]};
            bit_idx <= bit_idx + 3'd1;
          end
        end
        ramio_pkg::tx_stop: if (tick) state <= ramio_pkg::tx_done;
        // hold until the sender drops go
        ramio_pkg::tx_done: if (!go) state <= ramio_pkg::tx_idle;
        default: state <= ramio_pkg::tx_idle;
      endcase
    end
  end

  a_idle_line_high: assert property (@(posedge clk) disable iff (!rst_n)
    state == ramio_pkg::tx_idle |-> tx);

endmodule
